// ==== sim.f ====
logic/risk_pkg.sv
logic/ledger_pkg.sv
logic/ledger_if.sv
logic/client_ledger.sv
logic/limit_config.sv
logic/order_gate.sv
logic/cancel_tracker.sv
logic/risk_top.sv
test/tb_clock.sv
test/risk_tb.sv

// ==== Bender.yml ====
package:
  name: risk_gate

sources:
  - logic/risk_pkg.sv
  - logic/ledger_pkg.sv
  - logic/ledger_if.sv
  - logic/client_ledger.sv
  - logic/limit_config.sv
  - logic/order_gate.sv
  - logic/cancel_tracker.sv
  - logic/risk_top.sv
  - target: simulation
    files:
      - test/tb_clock.sv
      - test/risk_tb.sv

// ==== test/risk_tb.sv ====
/* table-driven testbench for the risk gate with a shadow model of limits and totals
   runs the directed table, a stalled-response check and an LFSR-driven random section */
`timescale 1ns/1ps
`default_nettype none

module risk_tb;

  import risk_pkg::*;

  typedef enum logic [2:0] {k_limit, k_halt, k_resume, k_cancel, k_order} kind_t;
  typedef struct packed {
    kind_t      kind;
    client_id_t client;
    logic [31:0] value;
    decision_t  exp_dec;
  } row_t;

  localparam int num_rows = 18;
  localparam int max_wait = 20;

  logic clk, rst_n;
  logic order_valid, order_ready, resp_valid, resp_ready;
  client_id_t order_client_id, resp_client_id, cxl_client_id, cfg_client_id;
  amount_t order_amount, cxl_amount;
  decision_t resp_decision;
  logic cxl_valid, cxl_ready, cfg_valid, cfg_ready;
  cfg_op_t cfg_op;
  total_t cfg_value;

  // shadow model state
  longint m_lim [32];
  longint m_acc [32];
  longint m_cxl [32];
  bit     m_halt;

  row_t        rows [num_rows];
  logic [31:0] lfsr_state = 32'h5fb0;
  int          checks;
  int          errors;
  bit          hung;

  tb_clock #(.half_period(20), .reset_cycles(2)) clock_gen (.clk(clk), .rst_n(rst_n));

  risk_top dut (
    .clk(clk), .rst_n(rst_n),
    .order_valid(order_valid), .order_ready(order_ready),
    .order_client_id(order_client_id), .order_amount(order_amount),
    .resp_valid(resp_valid), .resp_ready(resp_ready),
    .resp_decision(resp_decision), .resp_client_id(resp_client_id),
    .cxl_valid(cxl_valid), .cxl_ready(cxl_ready),
    .cxl_client_id(cxl_client_id), .cxl_amount(cxl_amount),
    .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_op(cfg_op),
    .cfg_client_id(cfg_client_id), .cfg_value(cfg_value)
  );

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t: %s, got %0d expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s within %0d cycles, stopping the run", what, max_wait);
    hung = 1'b1;
  endtask

  // galois form with one output bit per step
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // acceptance rule that books the amount on accept
  function automatic decision_t model_order(input client_id_t id, input amount_t amt);
    if (m_halt) begin
      return halted;
    end
    if (m_acc[id] + longint'(amt) <= m_lim[id] + m_cxl[id]) begin
      m_acc[id] = m_acc[id] + longint'(amt);
      return accepted;
    end
    return over_limit;
  endfunction

  // all send tasks start and end 2 ns after a rising edge
  task automatic send_cfg(input cfg_op_t op, input client_id_t id, input total_t value);
    int waited;
    cfg_valid = 1'b1;
    cfg_op = op;
    cfg_client_id = id;
    cfg_value = value;
    waited = 0;
    while (!cfg_ready && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!cfg_ready) begin
      note_timeout("cfg_ready never rose");
    end else begin
      @(posedge clk);
      #2;
      if (op == set_limit) m_lim[id] = value;
      if (op != set_limit) m_halt = (op == halt);
    end
    cfg_valid = 1'b0;
  endtask

  task automatic send_cancel(input client_id_t id, input amount_t amt);
    int waited;
    cxl_valid = 1'b1;
    cxl_client_id = id;
    cxl_amount = amt;
    waited = 0;
    while (!cxl_ready && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!cxl_ready) begin
      note_timeout("cxl_ready never rose before a cancellation");
    end else begin
      @(posedge clk);
      #2;
      m_cxl[id] = m_cxl[id] + longint'(amt);
    end
    cxl_valid = 1'b0;
    // let the read-modify-write finish so the next order sees it
    waited = 0;
    while (!hung && !cxl_ready && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!hung && !cxl_ready) note_timeout("cxl_ready stayed low after a cancellation");
  endtask

  task automatic send_order(input client_id_t id, input amount_t amt);
    int waited;
    order_valid = 1'b1;
    order_client_id = id;
    order_amount = amt;
    waited = 0;
    while (!order_ready && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!order_ready) begin
      note_timeout("order_ready never rose");
    end else begin
      @(posedge clk);
      #2;
    end
    order_valid = 1'b0;
  endtask

  task automatic wait_resp();
    int waited;
    waited = 0;
    while (!resp_valid && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!resp_valid) note_timeout("no response to an order");
  endtask

  task automatic run_order(input client_id_t id, input amount_t amt,
                           input decision_t tbl_dec, input bit from_table);
    decision_t exp_d;
    decision_t got_d;
    client_id_t got_c;
    exp_d = model_order(id, amt);
    if (from_table) check_eq(tbl_dec, exp_d, "table expectation disagrees with model");
    send_order(id, amt);
    if (!hung) wait_resp();
    if (!hung) begin
      got_d = resp_decision;
      got_c = resp_client_id;
      // the response transfers at this edge since resp_ready is high
      @(posedge clk);
      #2;
      check_eq(got_d, exp_d, $sformatf("decision for client %0d amount %0d", id, amt));
      check_eq(got_c, id, "resp_client_id");
    end
  endtask

  task automatic apply_row(input row_t r);
    case (r.kind)
      k_limit:  send_cfg(set_limit, r.client, r.value);
      k_halt:   send_cfg(halt, '0, '0);
      k_resume: send_cfg(resume, '0, '0);
      k_cancel: send_cancel(r.client, amount_t'(r.value));
      default:  run_order(r.client, amount_t'(r.value), r.exp_dec, 1'b1);
    endcase
  endtask

  initial begin
    int waited;
    int err_before;
    int orders;
    decision_t held_d;
    client_id_t held_c;
    client_id_t id;
    amount_t amt;

    order_valid = 1'b0;
    order_client_id = '0;
    order_amount = '0;
    resp_ready = 1'b1;
    cxl_valid = 1'b0;
    cxl_client_id = '0;
    cxl_amount = '0;
    cfg_valid = 1'b0;
    cfg_op = set_limit;
    cfg_client_id = '0;
    cfg_value = '0;
    checks = 0;
    errors = 0;
    hung = 1'b0;
    m_halt = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_lim[i] = 0;
      m_acc[i] = 0;
      m_cxl[i] = 0;
    end

    // rows cover no limit, headroom, cancellation, halt and resume
    rows = '{
      '{k_order, 5'd1, 32'd50, over_limit}, '{k_order, 5'd1, 32'd0, accepted},
      '{k_limit, 5'd1, 32'd100, accepted},  '{k_order, 5'd1, 32'd60, accepted},
      '{k_order, 5'd1, 32'd40, accepted},   '{k_order, 5'd1, 32'd1, over_limit},
      '{k_order, 5'd1, 32'd0, accepted},    '{k_limit, 5'd2, 32'd30, accepted},
      '{k_cancel, 5'd1, 32'd25, accepted},  '{k_order, 5'd1, 32'd20, accepted},
      '{k_order, 5'd2, 32'd31, over_limit}, '{k_order, 5'd2, 32'd30, accepted},
      '{k_halt, 5'd0, 32'd0, accepted},     '{k_order, 5'd1, 32'd5, halted},
      '{k_order, 5'd3, 32'd0, halted},      '{k_resume, 5'd0, 32'd0, accepted},
      '{k_order, 5'd1, 32'd5, accepted},    '{k_order, 5'd1, 32'd1, over_limit}
    };

    waited = 0;
    while (!rst_n && waited < max_wait) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!rst_n) note_timeout("reset never released");
    check_eq(order_ready, 1'b1, "order_ready after reset");
    check_eq(cxl_ready, 1'b1, "cxl_ready after reset");
    check_eq(cfg_ready, 1'b1, "cfg_ready after reset");
    check_eq(resp_valid, 1'b0, "resp_valid after reset");

    for (int i = 0; i < num_rows && !hung; i++) begin
      err_before = errors;
      apply_row(rows[i]);
      $display("row %0d %s client %0d value %0d: %s", i, rows[i].kind.name(),
               rows[i].client, rows[i].value, errors == err_before ? "ok" : "mismatch");
    end

    // stalled response holds its payload and blocks a second order
    if (!hung) begin
      err_before = errors;
      resp_ready = 1'b0;
      held_d = model_order(5'd1, 16'd0);
      send_order(5'd1, 16'd0);
      if (!hung) wait_resp();
      if (!hung) begin
        check_eq(resp_decision, held_d, "stalled decision");
        check_eq(resp_client_id, 5'd1, "stalled client id");
        held_c = resp_client_id;
        order_valid = 1'b1;
        order_client_id = 5'd2;
        order_amount = 16'd1;
        repeat (6) begin
          @(posedge clk);
          #2;
          check_eq(resp_valid, 1'b1, "resp_valid dropped during stall");
          check_eq(resp_decision, held_d, "resp_decision moved during stall");
          check_eq(resp_client_id, held_c, "resp_client_id moved during stall");
          check_eq(order_ready, 1'b0, "order_ready rose during stall");
        end
        order_valid = 1'b0;
        resp_ready = 1'b1;
        @(posedge clk);
        #2;
        check_eq(resp_valid, 1'b0, "resp_valid after stalled transfer");
        check_eq(order_ready, 1'b1, "order_ready after stalled transfer");
      end
      $display("stall test: %s", errors == err_before ? "ok" : "mismatch");
    end

    // random orders and cancellations on clients 4 to 7
    if (!hung) begin
      err_before = errors;
      orders = 0;
      for (int c = 4; c < 8; c++) begin
        send_cfg(set_limit, client_id_t'(c), 32'd150);
      end
      for (int n = 0; n < 40 && !hung; n++) begin
        id = client_id_t'(4 + take_bits(2));
        amt = amount_t'(take_bits(6));
        if (take_bits(2) == 0) begin
          send_cancel(id, amt);
        end else begin
          run_order(id, amt, accepted, 1'b0);
          orders++;
        end
      end
      $display("random test, %0d orders: %s", orders, errors == err_before ? "ok" : "mismatch");
    end

    $display("summary: %0d checks, %0d errors, timeout %0d", checks, errors, hung);
    if (errors == 0 && !hung) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
/* clock and reset source for the risk gate testbench
   40 ns clock, rst_n held low over the first two rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release on a falling edge, well away from the drive and sample points
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/risk_top.sv ====
/* top level of the pre-trade risk gate, orders upstream and cancellations downstream
   ties the config block, order checker, cancel tracker and both ledgers to plain ports */
`timescale 1ns/1ps
`default_nettype none

module risk_top #(
  parameter int depth = ledger_pkg::num_clients
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // order request
  input  logic                 order_valid,
  output logic                 order_ready,
  input  risk_pkg::client_id_t order_client_id,
  input  risk_pkg::amount_t    order_amount,
  // order response
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output risk_pkg::decision_t  resp_decision,
  output risk_pkg::client_id_t resp_client_id,
  // exchange cancellation
  input  logic                 cxl_valid,
  output logic                 cxl_ready,
  input  risk_pkg::client_id_t cxl_client_id,
  input  risk_pkg::amount_t    cxl_amount,
  // configuration
  input  logic                 cfg_valid,
  output logic                 cfg_ready,
  input  risk_pkg::cfg_op_t    cfg_op,
  input  risk_pkg::client_id_t cfg_client_id,
  input  risk_pkg::total_t     cfg_value
);

  import risk_pkg::*;

  // client ids index the ledgers directly
  if ($bits(client_id_t) != $bits(ledger_pkg::ledger_index_t)) begin : g_index_check
    $error("client id and ledger index widths differ");
  end

  ledger_pkg::ledger_index_t cxl_rd_index;
  total_t                    cxl_rd_data;
  client_id_t                lim_index;
  total_t                    lim_data;
  logic                      halted;

  ledger_if #(.depth(depth), .entry_t(total_t)) acc_if ();
  ledger_if #(.depth(depth), .entry_t(total_t)) cxl_if ();

  limit_config u_limit_config (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_valid     (cfg_valid),
    .cfg_ready     (cfg_ready),
    .cfg_op        (cfg_op),
    .cfg_client_id (cfg_client_id),
    .cfg_value     (cfg_value),
    .lim_index     (lim_index),
    .lim_data      (lim_data),
    .halted        (halted)
  );

  order_gate u_order_gate (
    .clk             (clk),
    .rst_n           (rst_n),
    .order_valid     (order_valid),
    .order_ready     (order_ready),
    .order_client_id (order_client_id),
    .order_amount    (order_amount),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .resp_decision   (resp_decision),
    .resp_client_id  (resp_client_id),
    .acc             (acc_if.user),
    .cxl_rd_index    (cxl_rd_index),
    .cxl_rd_data     (cxl_rd_data),
    .lim_index       (lim_index),
    .lim_data        (lim_data),
    .halted          (halted)
  );

  cancel_tracker u_cancel_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .cxl_valid     (cxl_valid),
    .cxl_ready     (cxl_ready),
    .cxl_client_id (cxl_client_id),
    .cxl_amount    (cxl_amount),
    .cxl           (cxl_if.user)
  );

  // accumulated totals, second read port idle
  client_ledger #(.depth(depth), .entry_t(total_t)) acc_ledger (
    .clk       (clk),
    .rst_n     (rst_n),
    .port      (acc_if.ledger),
    .rd2_index ('0),
    .rd2_data  ()
  );

  // cancelled totals, second read port feeds the order checker
  client_ledger #(.depth(depth), .entry_t(total_t)) cxl_ledger (
    .clk       (clk),
    .rst_n     (rst_n),
    .port      (cxl_if.ledger),
    .rd2_index (cxl_rd_index),
    .rd2_data  (cxl_rd_data)
  );

endmodule

`default_nettype wire

// ==== logic/cancel_tracker.sv ====
/* downstream side that adds each exchange cancellation into the cancelled ledger
   two-cycle read-modify-write where the total saturates instead of wrapping */
`timescale 1ns/1ps
`default_nettype none

module cancel_tracker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cxl_valid,
  output logic                 cxl_ready,
  input  risk_pkg::client_id_t cxl_client_id,
  input  risk_pkg::amount_t    cxl_amount,
  ledger_if.user               cxl
);

  import risk_pkg::*;

  localparam int sum_w = $bits(total_t) + 1;
  typedef logic [sum_w-1:0] sum_t;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_read  = 2'd1,
    st_write = 2'd2
  } state_t;

  state_t     state_q;
  client_id_t id_q;
  amount_t    amount_q;
  logic       cxl_fire;
  sum_t       new_sum;

  assign cxl_ready = (state_q == st_idle);
  assign cxl_fire  = cxl_valid && cxl_ready;

  assign cxl.rd_index = id_q;
  assign cxl.wr_index = id_q;

  // clamp at all ones on carry out
  assign new_sum     = sum_t'(cxl.rd_data) + sum_t'(amount_q);
  assign cxl.wr_en   = (state_q == st_write);
  assign cxl.wr_data = new_sum[sum_w-1] ? '1 : new_sum[sum_w-2:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:  if (cxl_fire) state_q <= st_read;
        st_read:  state_q <= st_write;
        st_write: state_q <= st_idle;
        default:  state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cxl_fire) begin
      id_q     <= cxl_client_id;
      amount_q <= cxl_amount;
    end
  end

endmodule

`default_nettype wire

// ==== logic/order_gate.sv ====
/* upstream order checker with one order in flight at a time
   reads accumulated, cancelled and limit for the client, decides, books accepts */
`timescale 1ns/1ps
`default_nettype none

module order_gate (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      order_valid,
  output logic                      order_ready,
  input  risk_pkg::client_id_t      order_client_id,
  input  risk_pkg::amount_t         order_amount,
  output logic                      resp_valid,
  input  logic                      resp_ready,
  output risk_pkg::decision_t       resp_decision,
  output risk_pkg::client_id_t      resp_client_id,
  ledger_if.user                    acc,
  output ledger_pkg::ledger_index_t cxl_rd_index,
  input  risk_pkg::total_t          cxl_rd_data,
  output risk_pkg::client_id_t      lim_index,
  input  risk_pkg::total_t          lim_data,
  input  logic                      halted
);

  import risk_pkg::*;

  // one spare bit so neither sum can wrap
  localparam int sum_w = $bits(total_t) + 1;
  typedef logic [sum_w-1:0] sum_t;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_lookup  = 2'd1,
    st_respond = 2'd2
  } state_t;

  state_t     state_q;
  logic       data_ready_q;
  client_id_t id_q;
  amount_t    amount_q;
  decision_t  decision_q;

  logic      order_fire;
  logic      decide;
  sum_t      need_sum;
  sum_t      room_sum;
  logic      fits;
  decision_t decision;

  assign order_ready = (state_q == st_idle);
  assign order_fire  = order_valid && order_ready;
  assign resp_valid  = (state_q == st_respond);

  // ledger and limit data are valid in the second lookup cycle
  assign decide = (state_q == st_lookup) && data_ready_q;

  // all three tables are indexed by the held client id
  assign acc.rd_index = id_q;
  assign cxl_rd_index = id_q;
  assign lim_index    = id_q;

  always_comb begin
    need_sum = sum_t'(acc.rd_data) + sum_t'(amount_q);
    room_sum = sum_t'(lim_data) + sum_t'(cxl_rd_data);
    // a booked total must still fit the table width
    fits = (need_sum <= room_sum) && !need_sum[sum_w-1];
    if (halted) begin
      decision = risk_pkg::halted;
    end else if (fits) begin
      decision = accepted;
    end else begin
      decision = over_limit;
    end
  end

  // book the new accumulated total on accept only
  assign acc.wr_en    = decide && (decision == accepted);
  assign acc.wr_index = id_q;
  assign acc.wr_data  = need_sum[sum_w-2:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= st_idle;
      data_ready_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          data_ready_q <= 1'b0;
          if (order_fire) begin
            state_q <= st_lookup;
          end
        end
        st_lookup: begin
          data_ready_q <= 1'b1;
          if (data_ready_q) begin
            state_q <= st_respond;
          end
        end
        st_respond: begin
          if (resp_ready) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // order payload and the decision it produced
  always_ff @(posedge clk) begin
    if (order_fire) begin
      id_q     <= order_client_id;
      amount_q <= order_amount;
    end
    if (decide) begin
      decision_q <= decision;
    end
  end

  assign resp_decision  = decision_q;
  assign resp_client_id = id_q;

  resp_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=>
      resp_valid && $stable(resp_decision) && $stable(resp_client_id)
  ) else $error("response changed while stalled");

endmodule

`default_nettype wire

// ==== logic/limit_config.sv ====
/* configuration registers for the risk gate, per-client limits and a global halt
   written over a valid/ready port, limits read back one cycle after the index */
`timescale 1ns/1ps
`default_nettype none

module limit_config (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_valid,
  output logic                cfg_ready,
  input  risk_pkg::cfg_op_t   cfg_op,
  input  risk_pkg::client_id_t cfg_client_id,
  input  risk_pkg::total_t    cfg_value,
  input  risk_pkg::client_id_t lim_index,
  output risk_pkg::total_t    lim_data,
  output logic                halted
);

  import risk_pkg::*;

  // one limit register per possible client id
  localparam int num_limits = 2 ** $bits(client_id_t);

  total_t limit_q [num_limits];
  logic   halt_q;
  logic   cfg_fire;

  // writes never stall
  assign cfg_ready = 1'b1;
  assign cfg_fire  = cfg_valid && cfg_ready;
  assign halted    = halt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_limits; i++) begin
        limit_q[i] <= '0;
      end
      halt_q   <= 1'b0;
      lim_data <= '0;
    end else begin
      if (cfg_fire) begin
        case (cfg_op)
          set_limit: limit_q[cfg_client_id] <= cfg_value;
          halt:      halt_q <= 1'b1;
          resume:    halt_q <= 1'b0;
          default:   halt_q <= halt_q;
        endcase
      end
      // registered read, same latency as the ledgers
      lim_data <= limit_q[lim_index];
    end
  end

  cfg_op_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_fire |-> cfg_op inside {set_limit, halt, resume}
  ) else $error("illegal configuration opcode %0d", cfg_op);

endmodule

`default_nettype wire

// ==== logic/client_ledger.sv ====
/* per-client table with a write port and two registered read ports
   payload type is a parameter so one table serves any per-client record */
`timescale 1ns/1ps
`default_nettype none

module client_ledger #(
  parameter int  depth   = ledger_pkg::num_clients,
  parameter type entry_t = risk_pkg::total_t
) (
  input  logic                      clk,
  input  logic                      rst_n,
  ledger_if.ledger                  port,
  input  ledger_pkg::ledger_index_t rd2_index,
  output entry_t                    rd2_data
);

  entry_t entries_q [depth];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // totals start from zero after reset
      for (int i = 0; i < depth; i++) begin
        entries_q[i] <= '0;
      end
      port.rd_data <= '0;
      rd2_data     <= '0;
    end else begin
      if (port.wr_en) begin
        entries_q[port.wr_index] <= port.wr_data;
      end
      // same-cycle write is not forwarded, reads see the old entry
      port.rd_data <= entries_q[port.rd_index];
      rd2_data     <= entries_q[rd2_index];
    end
  end

  // a write to an unknown slot would corrupt an arbitrary client
  wr_index_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    port.wr_en |-> !$isunknown(port.wr_index)
  ) else $error("ledger write with unknown index");

endmodule

`default_nettype wire

// ==== logic/ledger_if.sv ====
/* read/write bundle between a client ledger and the block that owns its contents
   read data lags the index by one cycle, writes land on the clock edge */
`timescale 1ns/1ps
`default_nettype none

interface ledger_if #(
  parameter int  depth   = ledger_pkg::num_clients,
  parameter type entry_t = risk_pkg::total_t
);

  typedef logic [$clog2(depth)-1:0] index_t;

  index_t rd_index;
  entry_t rd_data;
  logic   wr_en;
  index_t wr_index;
  entry_t wr_data;

  // block that reads and updates the table
  modport user (output rd_index, wr_en, wr_index, wr_data, input rd_data);

  // the table itself
  modport ledger (input rd_index, wr_en, wr_index, wr_data, output rd_data);

endinterface

`default_nettype wire

// ==== logic/ledger_pkg.sv ====
/* storage-side types for the per-client ledgers
   the index type lines up with the client id of the trading package */
`default_nettype none

package ledger_pkg;

  // one table entry per client
  localparam int num_clients = 32;

  // table index, same width as a client id
  typedef logic [$clog2(num_clients)-1:0] ledger_index_t;

endpackage

`default_nettype wire

// ==== logic/risk_pkg.sv ====
/* trading-side types shared by the risk gate blocks and its testbench
   covers client ids, amounts, running totals, config opcodes and decisions */
`default_nettype none

package risk_pkg;

  // one of up to 32 trading clients
  typedef logic [4:0] client_id_t;

  // amount carried by a single order or cancellation
  typedef logic [15:0] amount_t;

  // running totals and per-client limits
  typedef logic [31:0] total_t;

  // configuration write opcodes
  typedef enum logic [1:0] {
    set_limit = 2'd0,
    halt      = 2'd1,
    resume    = 2'd2
  } cfg_op_t;

  // response code returned for every order
  typedef enum logic [1:0] {
    accepted   = 2'd0,
    over_limit = 2'd1,
    halted     = 2'd2
  } decision_t;

endpackage

`default_nettype wire
